//--- vlog.f
+incdir+source
source/exec_pkg.sv
source/issue_decode.sv
source/reg_file.sv
source/operand_mux.sv
source/exec_alu.sv
source/write_back.sv
source/exec_top.sv
sim/exec_tb.sv

//--- sim/exec_tb.sv
// Testbench for the integer execute subsystem
// Clock, reset, watchdog, reference model with shadow registers
// Compare tasks and directed tests for forwarding, immediates and stalls
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_tb;

	import exec_pkg::*;

	localparam int clk_half      = 10;
	// Rough length of all tests, plus slack for the watchdog
	localparam int test_cycles   = 320;
	localparam int margin_cycles = 200;
	localparam int wait_limit    = 20;

	logic       clk;
	logic       reset;
	logic       issue_valid;
	instr_t     issue_instr;
	logic       id_stall;
	logic       ex_stall;
	logic       result_valid;
	wb_result_t result;

	// Reference state and expected results in issue order
	logic [`EXEC_DATA_W-1:0] shadow [`EXEC_NREGS];
	wb_result_t              exp_q [$];
	int                      exp_cyc [$];
	wb_result_t              got_q [$];
	int                      got_cyc [$];
	int                      cyc = 0;
	int                      errors = 0;
	int                      checks = 0;
	int                      tests = 0;
	int unsigned             seed_draw;

	exec_top dut0 (
		.clk(clk), .reset(reset),
		.issue_valid(issue_valid), .issue_instr(issue_instr),
		.id_stall(id_stall), .ex_stall(ex_stall),
		.result_valid(result_valid), .result(result)
	);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	// Cycle count, stable at the falling edge
	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// Collect every result pulse with its cycle
	always @(negedge clk) begin
		if (!reset && result_valid) begin
			got_q.push_back(result);
			got_cyc.push_back(cyc);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [`EXEC_DATA_W-1:0] ref_alu(
		input alu_op_e                 op,
		input logic [`EXEC_DATA_W-1:0] a,
		input logic [`EXEC_DATA_W-1:0] b
	);
		logic signed [`EXEC_DATA_W-1:0] sa;
		logic signed [`EXEC_DATA_W-1:0] sb;
		logic [4:0]                     sh;
		sa = a;
		sb = b;
		// Shift amount is the low 5 bits of B
		sh = b[4:0];
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			op_sll:  return a << sh;
			op_srl:  return a >> sh;
			op_slt:  return (sa < sb) ? `EXEC_DATA_W'(1) : '0;
			default: return '0;
		endcase
	endfunction

	function automatic instr_t make_instr(
		input alu_op_e                 op,
		input logic [`EXEC_REG_W-1:0]  rd,
		input logic [`EXEC_REG_W-1:0]  rs_a,
		input logic [`EXEC_REG_W-1:0]  rs_b,
		input logic                    use_imm,
		input logic [`EXEC_DATA_W-1:0] imm
	);
		instr_t ins;
		ins.op      = op;
		ins.rd      = rd;
		ins.rs_a    = rs_a;
		ins.rs_b    = rs_b;
		ins.use_imm = use_imm;
		ins.imm     = imm;
		return ins;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_result(input wb_result_t got, input wb_result_t want,
			input string name);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %s: got rd=%h data=%h, expected rd=%h data=%h",
				name, got.rd, got.data, want.rd, want.data);
		end
	endtask

	task automatic compare_count(input int got, input int want, input string name);
		checks++;
		if (got != want) begin
			errors++;
			$display("ERR %s: got %h, expected %h", name, got, want);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Drive helpers, all inputs change on the falling edge
	////////////////////////////////////////////////////////////////////////////

	// Issue one instruction and predict its result, extra is the EX stall length
	task automatic send(input instr_t ins, input int extra);
		logic [`EXEC_DATA_W-1:0] a;
		logic [`EXEC_DATA_W-1:0] b;
		wb_result_t              want;
		@(negedge clk);
		issue_valid = 1'b1;
		issue_instr = ins;
		id_stall    = 1'b0;
		ex_stall    = 1'b0;
		a = (ins.rs_a == '0) ? '0 : shadow[ins.rs_a];
		// Immediate replaces B, register 0 reads as zero
		if (ins.use_imm)
			b = ins.imm;
		else if (ins.rs_b == '0)
			b = '0;
		else
			b = shadow[ins.rs_b];
		want.rd   = ins.rd;
		want.data = ref_alu(ins.op, a, b);
		if (ins.rd != '0)
			shadow[ins.rd] = want.data;
		exp_q.push_back(want);
		exp_cyc.push_back(cyc + 2 + extra);
	endtask

	task automatic idle(input int n);
		@(negedge clk);
		issue_valid = 1'b0;
		id_stall    = 1'b0;
		ex_stall    = 1'b0;
		repeat (n - 1) @(negedge clk);
	endtask

	// Both stalls high for k edges, nothing issued meanwhile
	task automatic stall_ex(input int k);
		@(negedge clk);
		issue_valid = 1'b0;
		id_stall    = 1'b1;
		ex_stall    = 1'b1;
		repeat (k) @(negedge clk);
		id_stall = 1'b0;
		ex_stall = 1'b0;
	endtask

	// Present an instruction under id_stall for j edges, send releases it
	task automatic hold_issue(input instr_t ins, input int j);
		@(negedge clk);
		issue_valid = 1'b1;
		issue_instr = ins;
		id_stall    = 1'b1;
		ex_stall    = 1'b0;
		repeat (j - 1) @(negedge clk);
	endtask

	// Wait for all predicted results, then compare values, cycles and pulse count
	task automatic check_and_report(input string name, input int err_start);
		int waited;
		int n;
		waited = 0;
		while (got_q.size() < exp_q.size() && waited < wait_limit) begin
			@(posedge clk);
			waited++;
		end
		// A few more cycles expose any extra pulse
		repeat (4) @(posedge clk);
		compare_count(got_q.size(), exp_q.size(), "result_valid pulses");
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++) begin
			compare_result(got_q[i], exp_q[i], "result");
			compare_count(got_cyc[i], exp_cyc[i], "result_valid cycle");
		end
		got_q.delete();
		got_cyc.delete();
		exp_q.delete();
		exp_cyc.delete();
		tests++;
		if (errors == err_start)
			$display("%-16s ok", name);
		else
			$display("%-16s %0d error(s)", name, errors - err_start);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_reads();
		int e0;
		e0 = errors;
		repeat (5) @(posedge clk);
		compare_count(got_q.size(), 0, "result_valid after reset");
		// rd 0 keeps the register file untouched
		for (int r = 0; r < `EXEC_NREGS; r++) begin
			send(make_instr(op_add, 4'd0, `EXEC_REG_W'(r), 4'd0, 1'b1, 32'd0), 0);
		end
		idle(1);
		check_and_report("reset_reads", e0);
	endtask

	task automatic test_each_opcode();
		alu_op_e                 op;
		logic [`EXEC_DATA_W-1:0] va;
		logic [`EXEC_DATA_W-1:0] vb;
		int                      e0;
		e0 = errors;
		for (int k = 0; k < 8; k++) begin
			op = alu_op_e'(k);
			va = $urandom();
			vb = $urandom();
			send(make_instr(op_add, 4'd1, 4'd0, 4'd0, 1'b1, va), 0);
			send(make_instr(op_add, 4'd2, 4'd0, 4'd0, 1'b1, vb), 0);
			// Gap so the operation reads the register file only
			idle(3);
			send(make_instr(op, 4'd3, 4'd1, 4'd2, 1'b0, 32'd0), 0);
			idle(3);
		end
		check_and_report("each_opcode", e0);
	endtask

	task automatic test_forwarding();
		int e0;
		e0 = errors;
		send(make_instr(op_add, 4'd1, 4'd0, 4'd0, 1'b1, $urandom()), 0);
		// Back to back, EX forward on both sides
		send(make_instr(op_add, 4'd2, 4'd1, 4'd1, 1'b0, 32'd0), 0);
		send(make_instr(op_sub, 4'd3, 4'd2, 4'd1, 1'b0, 32'd0), 0);
		send(make_instr(op_xor, 4'd4, 4'd3, 4'd2, 1'b0, 32'd0), 0);
		// One apart, WB forward
		idle(1);
		send(make_instr(op_or, 4'd5, 4'd4, 4'd3, 1'b0, 32'd0), 0);
		idle(1);
		send(make_instr(op_and, 4'd6, 4'd1, 4'd5, 1'b0, 32'd0), 0);
		idle(3);
		check_and_report("forwarding", e0);
	endtask

	task automatic test_imm_override();
		int e0;
		e0 = errors;
		send(make_instr(op_add, 4'd5, 4'd0, 4'd0, 1'b1, $urandom()), 0);
		// rs_b hits the EX destination, immediate must win
		send(make_instr(op_add, 4'd6, 4'd5, 4'd5, 1'b1, $urandom()), 0);
		idle(1);
		// rs_b hits the WB destination
		send(make_instr(op_sub, 4'd7, 4'd5, 4'd6, 1'b1, $urandom()), 0);
		idle(3);
		check_and_report("imm_override", e0);
	endtask

	task automatic test_stalls();
		int e0;
		e0 = errors;
		for (int k = 1; k <= 3; k += 2) begin
			send(make_instr(op_xor, 4'd8, 4'd5, 4'd6, 1'b0, 32'd0), k);
			stall_ex(k);
			send(make_instr(op_add, 4'd9, 4'd8, 4'd8, 1'b0, 32'd0), 0);
			idle(3);
		end
		// Dependent instruction held in decode right behind its producer
		send(make_instr(op_add, 4'd10, 4'd0, 4'd0, 1'b1, $urandom()), 0);
		hold_issue(make_instr(op_or, 4'd11, 4'd10, 4'd5, 1'b0, 32'd0), 4);
		send(make_instr(op_or, 4'd11, 4'd10, 4'd5, 1'b0, 32'd0), 0);
		idle(3);
		check_and_report("stalls", e0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		// Seed the generator once
		seed_draw   = $urandom(12);
		reset       = 1'b1;
		issue_valid = 1'b0;
		issue_instr = '0;
		id_stall    = 1'b0;
		ex_stall    = 1'b0;
		for (int i = 0; i < `EXEC_NREGS; i++) begin
			shadow[i] = '0;
		end
		repeat (16) @(negedge clk);
		reset = 1'b0;

		test_reset_reads();
		test_each_opcode();
		test_forwarding();
		test_imm_override();
		test_stalls();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		#((test_cycles + margin_cycles) * 2 * clk_half);
		$display("Watchdog expired, tests did not finish within %0d cycles",
			test_cycles + margin_cycles);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- source/exec_top.sv
// Top level of the integer execute subsystem
// Decode, register file, operand mux, EX and WB stages
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 issue_valid,
	input  exec_pkg::instr_t     issue_instr,
	input  logic                 id_stall,
	input  logic                 ex_stall,
	output logic                 result_valid,
	output exec_pkg::wb_result_t result
);

	import exec_pkg::*;

	// Decode to register file and operand mux
	logic [`EXEC_REG_W-1:0]  rd_addr_a;
	logic [`EXEC_REG_W-1:0]  rd_addr_b;
	opnd_sel_e               sel_a;
	opnd_sel_e               sel_b;
	logic [`EXEC_DATA_W-1:0] simm;
	ex_ctrl_t                id_ctrl;
	logic [`EXEC_DATA_W-1:0] rf_data_a;
	logic [`EXEC_DATA_W-1:0] rf_data_b;
	logic [`EXEC_DATA_W-1:0] operand_a;
	logic [`EXEC_DATA_W-1:0] operand_b;

	// Forward paths
	wb_result_t ex_forw;
	logic       ex_forw_valid;
	wb_result_t wb_forw;
	logic       wb_forw_valid;

	issue_decode u_decode (
		.clk(clk), .reset(reset),
		.issue_valid(issue_valid), .issue_instr(issue_instr),
		.id_stall(id_stall), .ex_stall(ex_stall),
		.ex_forw(ex_forw), .ex_forw_valid(ex_forw_valid),
		.wb_forw(wb_forw), .wb_forw_valid(wb_forw_valid),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.sel_a(sel_a), .sel_b(sel_b), .simm(simm), .id_ctrl(id_ctrl)
	);

	// WB result is the write port
	reg_file u_rf (
		.clk(clk), .reset(reset),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.wr(wb_forw), .wr_en(wb_forw_valid),
		.rf_data_a(rf_data_a), .rf_data_b(rf_data_b)
	);

	operand_mux u_opmux (
		.clk(clk), .reset(reset), .id_stall(id_stall), .ex_stall(ex_stall),
		.rf_data_a(rf_data_a), .rf_data_b(rf_data_b),
		.ex_forw(ex_forw), .wb_forw(wb_forw), .simm(simm),
		.sel_a(sel_a), .sel_b(sel_b),
		.operand_a(operand_a), .operand_b(operand_b)
	);

	exec_alu u_alu (
		.clk(clk), .reset(reset), .ex_stall(ex_stall), .id_ctrl(id_ctrl),
		.operand_a(operand_a), .operand_b(operand_b),
		.ex_forw(ex_forw), .ex_forw_valid(ex_forw_valid)
	);

	write_back u_wb (
		.clk(clk), .reset(reset), .ex_stall(ex_stall),
		.ex_forw(ex_forw), .ex_forw_valid(ex_forw_valid),
		.wb_forw(wb_forw), .wb_forw_valid(wb_forw_valid),
		.result(result), .result_valid(result_valid)
	);

endmodule

//--- source/write_back.sv
// WB stage
// Result register, register file write port and result pulse
`timescale 1ns/1ps
`include "exec_macros.svh"

module write_back (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ex_stall,
	input  exec_pkg::wb_result_t ex_forw,
	input  logic                 ex_forw_valid,
	output exec_pkg::wb_result_t wb_forw,
	output logic                 wb_forw_valid,
	output exec_pkg::wb_result_t result,
	output logic                 result_valid
);

	import exec_pkg::*;

	wb_result_t wb_q;
	logic       wb_valid;

	// Payload follows EX every cycle
	always_ff @(posedge clk) begin
		wb_q <= ex_forw;
	end

	// A frozen EX instruction has not finished yet
	always_ff @(posedge clk) begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= ex_forw_valid && !ex_stall;
	end

	// Same value feeds forwarding, the write port and the output
	assign wb_forw       = wb_q;
	assign wb_forw_valid = wb_valid;
	assign result        = wb_q;
	assign result_valid  = wb_valid;

	// Frozen EX keeps its result and valid until the stall ends
	a_ex_frozen: assert property (
		@(posedge clk) disable iff (reset)
			ex_stall |=> $stable(ex_forw) && $stable(ex_forw_valid)
	);

endmodule

//--- source/exec_alu.sv
// EX stage
// Control register frozen by the EX stall
// Single cycle ALU driving the EX forward path
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_alu (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    ex_stall,
	input  exec_pkg::ex_ctrl_t      id_ctrl,
	input  logic [`EXEC_DATA_W-1:0] operand_a,
	input  logic [`EXEC_DATA_W-1:0] operand_b,
	output exec_pkg::wb_result_t    ex_forw,
	output logic                    ex_forw_valid
);

	import exec_pkg::*;

	ex_ctrl_t                ex_ctrl;
	logic [`EXEC_DATA_W-1:0] alu_res;
	logic                    lt;

	// Control moves with the operand registers
	always_ff @(posedge clk) begin
		if (reset)
			ex_ctrl <= '0;
		else if (!ex_stall)
			ex_ctrl <= id_ctrl;
	end

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////

	// Signed compare for slt
	assign lt = $signed(operand_a) < $signed(operand_b);

	always_comb begin
		case (ex_ctrl.op)
			op_add:  alu_res = operand_a + operand_b;
			op_sub:  alu_res = operand_a - operand_b;
			op_and:  alu_res = operand_a & operand_b;
			op_or:   alu_res = operand_a | operand_b;
			op_xor:  alu_res = operand_a ^ operand_b;
			// Shift amount from the low 5 bits
			op_sll:  alu_res = operand_a << operand_b[4:0];
			op_srl:  alu_res = operand_a >> operand_b[4:0];
			op_slt:  alu_res = {{(`EXEC_DATA_W-1){1'b0}}, lt};
			default: alu_res = '0;
		endcase
	end

	// Result goes back to decode for forwarding and on to WB
	assign ex_forw.rd    = ex_ctrl.rd;
	assign ex_forw.data  = alu_res;
	assign ex_forw_valid = ex_ctrl.valid;

endmodule

//--- source/operand_mux.sv
// Operand multiplexers and operand registers
// Source select between register file, immediate, EX and WB forwards
// Freeze handling with saved flags while decode is held
`timescale 1ns/1ps
`include "exec_macros.svh"

module operand_mux (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    id_stall,
	input  logic                    ex_stall,
	input  logic [`EXEC_DATA_W-1:0] rf_data_a,
	input  logic [`EXEC_DATA_W-1:0] rf_data_b,
	input  exec_pkg::wb_result_t    ex_forw,
	input  exec_pkg::wb_result_t    wb_forw,
	input  logic [`EXEC_DATA_W-1:0] simm,
	input  exec_pkg::opnd_sel_e     sel_a,
	input  exec_pkg::opnd_sel_e     sel_b,
	output logic [`EXEC_DATA_W-1:0] operand_a,
	output logic [`EXEC_DATA_W-1:0] operand_b
);

	import exec_pkg::*;

	// Index 0 is operand A, index 1 is operand B
	logic [`EXEC_DATA_W-1:0] muxed [2];
	logic [`EXEC_DATA_W-1:0] opnd_q [2];
	logic [1:0]              saved;
	logic [1:0]              load;

	// One source mux, decode never asks for the immediate on A
	function automatic logic [`EXEC_DATA_W-1:0] pick(
		input opnd_sel_e               sel,
		input logic [`EXEC_DATA_W-1:0] rf_data
	);
		case (sel)
			sel_imm:     pick = simm;
			sel_ex_forw: pick = ex_forw.data;
			sel_wb_forw: pick = wb_forw.data;
			default:     pick = rf_data;
		endcase
	endfunction

	always_comb begin
		muxed[0] = pick(sel_a, rf_data_a);
		muxed[1] = pick(sel_b, rf_data_b);
	end

	// Load whenever EX moves, unless a held operand is already saved
	assign load[0] = !ex_stall && !saved[0];
	assign load[1] = !ex_stall && !saved[1];

	////////////////////////////////////////////////////////////////////////////
	// Operand registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2; i++) begin
				opnd_q[i] <= '0;
			end
			saved <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (load[i]) begin
					opnd_q[i] <= muxed[i];
					// Capture once while decode is held
					saved[i] <= id_stall;
				end else if (!ex_stall && !id_stall) begin
					// Held instruction issues with the saved value
					saved[i] <= 1'b0;
				end
			end
		end
	end

	assign operand_a = opnd_q[0];
	assign operand_b = opnd_q[1];

	// Immediate only ever feeds operand B
	a_a_no_imm: assert property (
		@(posedge clk) disable iff (reset) sel_a != sel_imm
	);

endmodule

//--- source/reg_file.sv
// Register file of the execute subsystem
// Two asynchronous read ports, one synchronous write port
// Register 0 reads as zero
`timescale 1ns/1ps
`include "exec_macros.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`EXEC_REG_W-1:0]  rd_addr_a,
	input  logic [`EXEC_REG_W-1:0]  rd_addr_b,
	input  exec_pkg::wb_result_t    wr,
	input  logic                    wr_en,
	output logic [`EXEC_DATA_W-1:0] rf_data_a,
	output logic [`EXEC_DATA_W-1:0] rf_data_b
);

	import exec_pkg::*;

	// Register array
	logic [`EXEC_DATA_W-1:0] regs [`EXEC_NREGS];

	// Write port, writes to register 0 are dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `EXEC_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr.rd != '0) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// Reads see the old value during a write
	// WB forwarding covers the same cycle
	always_comb begin
		if (rd_addr_a == '0)
			rf_data_a = '0;
		else
			rf_data_a = regs[rd_addr_a];

		if (rd_addr_b == '0)
			rf_data_b = '0;
		else
			rf_data_b = regs[rd_addr_b];
	end

endmodule

//--- source/issue_decode.sv
// Issue decode stage
// Register file read addresses, operand source selection with forwarding
// EX control struct qualified by the decode stall
`timescale 1ns/1ps
`include "exec_macros.svh"

module issue_decode (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    issue_valid,
	input  exec_pkg::instr_t        issue_instr,
	input  logic                    id_stall,
	// Only used by the stall ordering check
	input  logic                    ex_stall,
	input  exec_pkg::wb_result_t    ex_forw,
	input  logic                    ex_forw_valid,
	input  exec_pkg::wb_result_t    wb_forw,
	input  logic                    wb_forw_valid,
	output logic [`EXEC_REG_W-1:0]  rd_addr_a,
	output logic [`EXEC_REG_W-1:0]  rd_addr_b,
	output exec_pkg::opnd_sel_e     sel_a,
	output exec_pkg::opnd_sel_e     sel_b,
	output logic [`EXEC_DATA_W-1:0] simm,
	output exec_pkg::ex_ctrl_t      id_ctrl
);

	import exec_pkg::*;

	// Forwarding priority for one source register
	// EX result is newer than WB result, register 0 never forwards
	function automatic opnd_sel_e fwd_sel(input logic [`EXEC_REG_W-1:0] src);
		if (src == '0)
			fwd_sel = sel_reg_file;
		else if (ex_forw_valid && ex_forw.rd == src)
			fwd_sel = sel_ex_forw;
		else if (wb_forw_valid && wb_forw.rd == src)
			fwd_sel = sel_wb_forw;
		else
			fwd_sel = sel_reg_file;
	endfunction

	// Register file read ports follow the sources directly
	assign rd_addr_a = issue_instr.rs_a;
	assign rd_addr_b = issue_instr.rs_b;
	assign simm      = issue_instr.imm;

	always_comb begin
		sel_a = fwd_sel(issue_instr.rs_a);
		// Immediate wins over any forward on operand B
		if (issue_instr.use_imm)
			sel_b = sel_imm;
		else
			sel_b = fwd_sel(issue_instr.rs_b);
	end

	// Control for EX, a held instruction is not issued
	always_comb begin
		id_ctrl.op    = issue_instr.op;
		id_ctrl.rd    = issue_instr.rd;
		id_ctrl.valid = issue_valid && !id_stall;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// An EX freeze must always freeze decode too
	a_stall_order: assert property (
		@(posedge clk) disable iff (reset) ex_stall |-> id_stall
	);

endmodule

//--- source/exec_pkg.sv
// Shared types of the integer execute subsystem
// ALU opcode enum, operand source enum
// Instruction, EX control and result structs
`include "exec_macros.svh"

package exec_pkg;

	// ALU opcodes, one per cycle, all single cycle
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		op_sll = 3'd5,
		op_srl = 3'd6,
		op_slt = 3'd7
	} alu_op_e;

	// Operand source, same encoding as the classic forwarding mux
	typedef enum logic [1:0] {
		sel_reg_file = 2'd0,
		sel_imm      = 2'd1,
		sel_ex_forw  = 2'd2,
		sel_wb_forw  = 2'd3
	} opnd_sel_e;

	// Issued instruction
	typedef struct packed {
		alu_op_e                 op;
		logic [`EXEC_REG_W-1:0]  rd;
		logic [`EXEC_REG_W-1:0]  rs_a;
		logic [`EXEC_REG_W-1:0]  rs_b;
		logic                    use_imm;
		logic [`EXEC_DATA_W-1:0] imm;
	} instr_t;

	// Control handed from decode to EX
	typedef struct packed {
		alu_op_e                op;
		logic [`EXEC_REG_W-1:0] rd;
		logic                   valid;
	} ex_ctrl_t;

	// Destination and value, for forwarding, write back and output
	typedef struct packed {
		logic [`EXEC_REG_W-1:0]  rd;
		logic [`EXEC_DATA_W-1:0] data;
	} wb_result_t;

endpackage

//--- source/exec_macros.svh
// Width and size macros for the integer execute subsystem
// Data width, register count and register index width
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////////////////////

// Operand and result width
`define EXEC_DATA_W 32

// Number of architectural registers, register 0 reads as zero
`define EXEC_NREGS 16

// Register index width, enough for EXEC_NREGS
`define EXEC_REG_W 4

`endif
